// File: verilog/rv_mini_pkg.sv
package rv_mini_pkg;

    ////////////////////
    // basic word types
    ////////////////////

    // register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    // data and address word
    typedef logic [31:0] xword_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;

    // funct3 of the arithmetic group
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 of register-register forms
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // alu operations, pass_b carries the lui immediate
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    ////////////////////
    // instruction views
    ////////////////////

    // r-type layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    // i-type layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // one fetched word, read through either layout
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

// File: verilog/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch import rv_mini_pkg::*; #(
    parameter int imem_depth = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          stall,
    input  logic                          prog_valid,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  xword_t                        prog_data,
    output logic                          prog_ready,
    output logic                          if_valid,
    output xword_t                        if_instr,
    output xword_t                        if_pc
);

    localparam int aw = $clog2(imem_depth);

    // instruction store, written only while stopped
    xword_t imem [imem_depth];

    xword_t    pc;
    xword_t    fetch_word;
    logic      run_q;
    logic      halted;
    logic      fetch_ok;
    logic      issue;

    // host may load only while the core is stopped
    assign prog_ready = ~run;

    always_ff @(posedge clk) begin
        if (prog_valid && prog_ready) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // word at the current pc, word index from pc bits above the byte offset
    assign fetch_word = imem[pc[aw+1:2]];

    // only the three supported opcodes go on, an all-zero word fails this too
    assign fetch_ok = (fetch_word[6:0] == op_op) ||
                      (fetch_word[6:0] == op_op_imm) ||
                      (fetch_word[6:0] == op_lui);

    // run_q delays the first fetch by one edge after run is seen
    assign issue = run && run_q && !halted && !stall;

    ////////////////////
    // pc and control
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            pc       <= '0;
            if_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            run_q <= run;
            if (!run) begin
                // stopped, rewind for the next program
                pc       <= '0;
                if_valid <= 1'b0;
                halted   <= 1'b0;
            end else if (!stall) begin
                if (issue && fetch_ok) begin
                    if_valid <= 1'b1;
                    pc       <= pc + 32'd4;
                end else begin
                    if_valid <= 1'b0;
                    // halt marker or foreign opcode, stay stopped until run falls
                    if (issue) begin
                        halted <= 1'b1;
                    end
                end
            end
        end
    end

    // fetch register payload
    always_ff @(posedge clk) begin
        if (issue && fetch_ok) begin
            if_instr <= fetch_word;
            if_pc    <= pc;
        end
    end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_mini_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  xword_t    wr_data,
    input  reg_addr_t dbg_addr,
    output xword_t    rs1_data,
    output xword_t    rs2_data,
    output xword_t    dbg_data
);

    xword_t regs [32];

    // write port, x0 never written so it stays zero from reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // operand reads, no write bypass here
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // debug read, one cycle behind the address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbg_data <= '0;
        end else begin
            dbg_data <= regs[dbg_addr];
        end
    end

endmodule

// File: verilog/rv_decode_exec.sv
`timescale 1ns/10ps

module rv_decode_exec import rv_mini_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      if_valid,
    input  xword_t    if_instr,
    input  xword_t    rs1_data,
    input  xword_t    rs2_data,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    input  xword_t    wb_data,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      ex_valid,
    output reg_addr_t ex_rd,
    output xword_t    ex_result
);

    // operand b sources
    localparam logic [1:0] bsel_reg = 2'd0;
    localparam logic [1:0] bsel_imm = 2'd1;
    localparam logic [1:0] bsel_lui = 2'd2;

    instr_u    ins;
    alu_op_t   alu_op;
    logic [1:0] b_sel;
    logic      supported;
    xword_t    op_a;
    xword_t    rs2_fwd;
    xword_t    op_b;
    xword_t    imm_i;
    xword_t    imm_u;
    xword_t    alu_res;

    // youngest producer wins, then the retire register, then the file
    function automatic xword_t fwd(input reg_addr_t addr, input xword_t rf_val);
        if ((addr != '0) && ex_valid && (ex_rd == addr)) begin
            return ex_result;
        end
        if ((addr != '0) && wb_valid && (wb_rd == addr)) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    assign ins = if_instr;

    // register operands through the r-type view
    assign rs1_addr = ins.r.rs1;
    assign rs2_addr = ins.r.rs2;

    // immediates through the i-type view
    assign imm_i = {{20{ins.i.imm12[11]}}, ins.i.imm12};
    assign imm_u = {ins.i.imm12, ins.i.rs1, ins.i.funct3, 12'h000};

    ////////////////////
    // decode
    ////////////////////
    always_comb begin
        alu_op    = alu_add;
        b_sel     = bsel_reg;
        supported = 1'b1;
        case (ins.r.opcode)
            op_op: begin
                case (ins.r.funct3)
                    f3_add_sub: alu_op = (ins.r.funct7 == f7_sub) ? alu_sub : alu_add;
                    f3_slt:     alu_op = alu_slt;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    supported = 1'b0;
                endcase
                // only the base funct7, plus sub on add_sub
                if ((ins.r.funct7 != f7_base) &&
                    !((ins.r.funct7 == f7_sub) && (ins.r.funct3 == f3_add_sub))) begin
                    supported = 1'b0;
                end
            end
            op_op_imm: begin
                b_sel = bsel_imm;
                case (ins.i.funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_slt:     alu_op = alu_slt;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    // shifts not in the subset
                    default:    supported = 1'b0;
                endcase
            end
            op_lui: begin
                b_sel  = bsel_lui;
                alu_op = alu_pass_b;
            end
            default: supported = 1'b0;
        endcase
    end

    // operand selection
    always_comb begin
        op_a    = fwd(rs1_addr, rs1_data);
        rs2_fwd = fwd(rs2_addr, rs2_data);
        case (b_sel)
            bsel_imm: op_b = imm_i;
            bsel_lui: op_b = imm_u;
            default:  op_b = rs2_fwd;
        endcase
    end

    // alu
    always_comb begin
        case (alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    ////////////////////
    // result register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            // unsupported encodings drop out as a bubble
            ex_valid <= if_valid && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_rd     <= ins.r.rd;
            ex_result <= alu_res;
        end
    end

endmodule

// File: verilog/rv_writeback.sv
`timescale 1ns/10ps

module rv_writeback import rv_mini_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  xword_t    ex_result,
    input  logic      retire_ready,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output xword_t    retire_data,
    output logic      stall,
    output logic      wb_we,
    output reg_addr_t wb_rd,
    output xword_t    wb_data
);

    logic load_en;
    logic accept;

    // retire handshake
    assign accept = retire_valid && retire_ready;

    // free slot, either empty or draining this cycle
    assign load_en = !retire_valid || retire_ready;

    // full and held back, freeze everything upstream
    assign stall = !load_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else if (load_en) begin
            retire_valid <= ex_valid;
        end
    end

    // payload only moves with a new instruction
    always_ff @(posedge clk) begin
        if (load_en && ex_valid) begin
            retire_rd   <= ex_rd;
            retire_data <= ex_result;
        end
    end

    // register file write on the handshake, x0 skipped
    assign wb_we   = accept && (retire_rd != '0);
    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_mini_pkg::*; #(
    parameter int imem_depth = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          prog_valid,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  xword_t                        prog_data,
    input  logic                          retire_ready,
    input  reg_addr_t                     dbg_addr,
    output logic                          prog_ready,
    output logic                          retire_valid,
    output reg_addr_t                     retire_rd,
    output xword_t                        retire_data,
    output xword_t                        dbg_data
);

    // fetch to decode/exec
    logic      if_valid;
    xword_t    if_instr;

    // decode/exec to register file
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xword_t    rs1_data;
    xword_t    rs2_data;

    // decode/exec to writeback
    logic      ex_valid;
    reg_addr_t ex_rd;
    xword_t    ex_result;

    // writeback to register file and upstream
    logic      stall;
    logic      wb_we;
    reg_addr_t wb_rd;
    xword_t    wb_data;

    rv_fetch #(
        .imem_depth (imem_depth)
    ) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .stall      (stall),
        .prog_valid (prog_valid),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_ready (prog_ready),
        .if_valid   (if_valid),
        .if_instr   (if_instr),
        .if_pc      ()
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (wb_we),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .dbg_addr (dbg_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

    // retire register doubles as the second forwarding source
    rv_decode_exec u_decode_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .if_valid  (if_valid),
        .if_instr  (if_instr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (retire_valid),
        .wb_rd     (retire_rd),
        .wb_data   (retire_data),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result)
    );

    rv_writeback u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .stall        (stall),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

// File: sim/rv_core_sva.sv
`timescale 1ns/10ps

module rv_core_sva import rv_mini_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      run,
    input logic      prog_ready,
    input logic      stall,
    input logic      retire_valid,
    input logic      retire_ready,
    input reg_addr_t retire_rd,
    input xword_t    retire_data
);

    // retire payload held until accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && !retire_ready) |=>
            (retire_valid && $stable(retire_data) && $stable(retire_rd)))
        else $error("retire payload changed under back-pressure");

    // empty retire slot coming out of reset
    assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid)
        else $error("retire_valid high right after reset");

    // loading only while stopped
    assert property (@(posedge clk) disable iff (!rst_n) prog_ready == !run)
        else $error("prog_ready does not follow the inverse of run");

    assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(retire_rd))
        else $error("retire_rd moved while stalled");

endmodule

// fetch and writeback signals both meet in the core
bind rv_core rv_core_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .prog_ready   (prog_ready),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
);

// File: sim/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb import rv_mini_pkg::*; ();

    localparam int imem_depth  = 16;
    localparam int aw          = $clog2(imem_depth);
    localparam int max_prog    = imem_depth - 1;
    localparam int wait_limit  = 200;
    localparam int halt_window = 40;

    logic      clk;
    logic      rst_n;
    logic      run;
    logic      prog_valid;
    logic [aw-1:0] prog_addr;
    xword_t    prog_data;
    logic      retire_ready;
    reg_addr_t dbg_addr;
    logic      prog_ready;
    logic      retire_valid;
    reg_addr_t retire_rd;
    xword_t    retire_data;
    xword_t    dbg_data;

    // program table with expected retire values
    xword_t    tbl_word [max_prog];
    reg_addr_t tbl_rd   [max_prog];
    xword_t    tbl_val  [max_prog];
    int        n_prog;

    // final register contents after the program
    xword_t    exp_regs [32];

    logic [31:0] lfsr;
    int          error_count;
    int          timeout_count;

    rv_core #(
        .imem_depth (imem_depth)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .prog_valid   (prog_valid),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .retire_ready (retire_ready),
        .dbg_addr     (dbg_addr),
        .prog_ready   (prog_ready),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .dbg_data     (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // encoders
    ////////////////////
    function automatic xword_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic xword_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm12);
        return {imm12, rs1, f3, rd, op_op_imm};
    endfunction

    function automatic xword_t enc_u(input reg_addr_t rd, input logic [19:0] imm20);
        return {imm20, rd, op_lui};
    endfunction

    // galois lfsr x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic add_entry(input xword_t word, input reg_addr_t rd, input xword_t val);
        tbl_word[n_prog] = word;
        tbl_rd[n_prog]   = rd;
        tbl_val[n_prog]  = val;
        n_prog++;
    endtask

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_word(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // values worked out by hand from the isa
    task automatic build_table();
        n_prog = 0;
        add_entry(enc_i(f3_add_sub, 5'd1, 5'd0, 12'h005), 5'd1, 32'h0000_0005);
        add_entry(enc_i(f3_add_sub, 5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd);
        // x2 at distance one and x1 at distance two
        add_entry(enc_r(f7_base, f3_add_sub, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0002);
        add_entry(enc_r(f7_sub, f3_add_sub, 5'd4, 5'd2, 5'd1), 5'd4, 32'hffff_fff8);
        add_entry(enc_r(f7_base, f3_slt, 5'd5, 5'd4, 5'd1), 5'd5, 32'h0000_0001);
        add_entry(enc_r(f7_base, f3_slt, 5'd6, 5'd1, 5'd4), 5'd6, 32'h0000_0000);
        add_entry(enc_u(5'd7, 20'h12345), 5'd7, 32'h1234_5000);
        add_entry(enc_i(f3_or, 5'd7, 5'd7, 12'h678), 5'd7, 32'h1234_5678);
        add_entry(enc_i(f3_xor, 5'd8, 5'd7, 12'hfff), 5'd8, 32'hedcb_a987);
        add_entry(enc_r(f7_base, f3_and, 5'd9, 5'd8, 5'd2), 5'd9, 32'hedcb_a985);
        add_entry(enc_i(f3_and, 5'd10, 5'd7, 12'h0f0), 5'd10, 32'h0000_0070);
        add_entry(enc_r(f7_base, f3_xor, 5'd11, 5'd10, 5'd9), 5'd11, 32'hedcb_a9f5);
        add_entry(enc_i(f3_slt, 5'd12, 5'd2, 12'hffe), 5'd12, 32'h0000_0001);
        add_entry(enc_r(f7_base, f3_or, 5'd13, 5'd12, 5'd10), 5'd13, 32'h0000_0071);
        // x0 target retires but leaves the file alone
        add_entry(enc_r(f7_base, f3_add_sub, 5'd0, 5'd1, 5'd1), 5'd0, 32'h0000_000a);
        for (int i = 0; i < 32; i++) begin
            exp_regs[i] = '0;
        end
        for (int k = 0; k < n_prog; k++) begin
            if (tbl_rd[k] != '0) begin
                exp_regs[tbl_rd[k]] = tbl_val[k];
            end
        end
    endtask

    ////////////////////
    // sequences
    ////////////////////
    // table words then the zero halt marker
    task automatic load_program();
        int w;
        for (int k = 0; k <= n_prog; k++) begin
            @(negedge clk);
            prog_valid = 1'b1;
            prog_addr  = k[aw-1:0];
            prog_data  = (k < n_prog) ? tbl_word[k] : '0;
            w = 0;
            while (!prog_ready && (w < wait_limit)) begin
                @(negedge clk);
                w++;
            end
            if (!prog_ready) begin
                $display("prog_ready never came for program word %0d", k);
                timeout_count++;
                return;
            end
            @(posedge clk);
        end
        @(negedge clk);
        prog_valid = 1'b0;
    endtask

    // handshake decided at the negedge where ready is driven
    task automatic run_program(input logic random_ready, input logic check_latency);
        int   cyc;
        int   idx;
        int   first_cyc;
        logic rdy;
        @(negedge clk);
        run       = 1'b1;
        cyc       = 0;
        idx       = 0;
        first_cyc = 0;
        while ((idx < n_prog) && (cyc < wait_limit)) begin
            @(negedge clk);
            cyc++;
            if (cyc == 1) begin
                check_bit("prog_ready", prog_ready, 1'b0);
            end
            if (retire_valid && (first_cyc == 0)) begin
                first_cyc = cyc;
            end
            rdy = 1'b1;
            if (random_ready) begin
                lfsr = lfsr_next(lfsr);
                rdy  = lfsr[0];
            end
            retire_ready = rdy;
            if (retire_valid && rdy) begin
                check_reg("retire_rd", retire_rd, tbl_rd[idx]);
                check_word("retire_data", retire_data, tbl_val[idx]);
                idx++;
            end
        end
        if (idx < n_prog) begin
            $display("only %0d of %0d instructions retired before the timeout", idx, n_prog);
            timeout_count++;
        end else if (check_latency) begin
            // edges counted from the one that samples run
            check_word("first_retire_edges", xword_t'(first_cyc - 1), 32'd3);
        end
    endtask

    // nothing may follow the halt marker
    task automatic watch_halt();
        @(negedge clk);
        retire_ready = 1'b1;
        for (int c = 0; c < halt_window; c++) begin
            @(negedge clk);
            if (retire_valid) begin
                $display("an instruction retired after the halt marker at %0t", $time);
                error_count++;
            end
        end
    endtask

    task automatic stop_core();
        @(negedge clk);
        run = 1'b0;
        @(negedge clk);
        check_bit("prog_ready", prog_ready, 1'b1);
    endtask

    task automatic check_debug();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            dbg_addr = r[4:0];
            @(negedge clk);
            check_word($sformatf("dbg_data x%0d", r), dbg_data, exp_regs[r]);
        end
    endtask

    ////////////////////
    // main flow
    ////////////////////
    initial begin
        rst_n         = 1'b0;
        run           = 1'b0;
        prog_valid    = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        retire_ready  = 1'b1;
        dbg_addr      = '0;
        lfsr          = 32'hfc2c_9cb3;
        error_count   = 0;
        timeout_count = 0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("prog_ready", prog_ready, 1'b1);
        check_bit("retire_valid", retire_valid, 1'b0);
        load_program();
        // first pass with retire_ready held high
        if (timeout_count == 0) begin
            run_program(1'b0, 1'b1);
            watch_halt();
        end
        // same program again under random back-pressure
        if (timeout_count == 0) begin
            stop_core();
            run_program(1'b1, 1'b0);
            watch_halt();
        end
        if (timeout_count == 0) begin
            check_debug();
        end
        $display("checks done with %0d errors and %0d timeouts", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/rv_mini_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode_exec.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f flist.f

out=$(./obj_dir/Vrv_core_tb)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"
